// File: bench/frame_writer_checks.svh
`ifndef FRAME_WRITER_CHECKS_SVH
`define FRAME_WRITER_CHECKS_SVH

// error counters shared by the whole bench
int value_errs  = 0;
int other_errs  = 0;
int blocks_seen = 0;

task automatic check_addr(
  input string                 name,
  input logic [addr_bits-1:0]  expected,
  input logic [addr_bits-1:0]  actual
);
  if (actual !== expected) begin
    value_errs++;
    $display("ERR %s expected %0d actual %0d", name, expected, actual);
  end
endtask

task automatic check_block(
  input string                  name,
  input logic [block_bits-1:0]  expected,
  input logic [block_bits-1:0]  actual
);
  if (actual !== expected) begin
    value_errs++;
    $display("ERR %s expected %h actual %h", name, expected, actual);
  end
endtask

// protocol problems that have no single expected value
task automatic report_problem(input string what);
  other_errs++;
  $display("%s (time %0t)", what, $time);
endtask

task automatic print_counts();
  $display("blocks checked %0d, value errors %0d, other errors %0d",
           blocks_seen, value_errs, other_errs);
endtask

`endif

// File: bench/frame_writer_tb.sv
`default_nettype none

module frame_writer_tb
  import raster_pkg::*;
();

  localparam int num_frames       = 3;
  localparam int blocks_per_frame = frame_width * frame_height / pixels_per_block;
  localparam int total_blocks     = num_frames * blocks_per_frame;
  localparam int cycle_limit      = num_frames * frame_width * frame_height * 4;
  localparam int last_blk_addr    = frame_width * frame_height - pixels_per_block;
  localparam int max_delay        = 20;

  logic                   sys_clk;
  logic                   sys_rst;
  logic                   tri_load;
  logic [coord_bits-1:0]  tri_x0;
  logic [coord_bits-1:0]  tri_y0;
  logic [coord_bits-1:0]  tri_x1;
  logic [coord_bits-1:0]  tri_y1;
  logic [coord_bits-1:0]  tri_x2;
  logic [coord_bits-1:0]  tri_y2;
  logic                   credit_return;
  logic                   blk_valid;
  logic [addr_bits-1:0]   blk_addr;
  logic [block_bits-1:0]  blk_data;

  // triangle per frame, vertex order x0 y0 x1 y1 x2 y2
  int tri_v[0:num_frames][0:5];
  // cycles at which received blocks hand their credit back
  int rel_q[$];
  int ready_cnt   = 0;
  int pause_until = 0;
  int outstanding = 0;
  int cyc         = 0;
  int n_blk       = 0;
  int load_frame  = 0;
  bit load_req    = 1'b0;
  bit timed_out   = 1'b0;
  logic [addr_bits-1:0] exp_addr = '0;

  `include "frame_writer_checks.svh"

  initial begin
    sys_clk = 1'b0;
    forever #4 sys_clk = ~sys_clk;
  end

  frame_writer i_frame_writer (
    .sys_clk       (sys_clk),
    .sys_rst       (sys_rst),
    .tri_load      (tri_load),
    .tri_x0        (tri_x0),
    .tri_y0        (tri_y0),
    .tri_x1        (tri_x1),
    .tri_y1        (tri_y1),
    .tri_x2        (tri_x2),
    .tri_y2        (tri_y2),
    .credit_return (credit_return),
    .blk_valid     (blk_valid),
    .blk_addr      (blk_addr),
    .blk_data      (blk_data)
  );

  // inside test on integer edge values, either winding counts
  function automatic bit inside_tri(input int f, input int px, input int py);
    int ax, ay, bx, by, s;
    bit pos;
    bit neg;
    pos = 1'b1;
    neg = 1'b1;
    for (int k = 0; k < 3; k++) begin
      ax = tri_v[f][2*k];
      ay = tri_v[f][2*k+1];
      bx = tri_v[f][(2*k+2) % 6];
      by = tri_v[f][(2*k+3) % 6];
      s = (px - ax) * (by - ay) - (py - ay) * (bx - ax);
      if (s < 0) pos = 1'b0;
      if (s > 0) neg = 1'b0;
    end
    return pos || neg;
  endfunction

  // a block never crosses a line, so all slots share one y
  function automatic logic [block_bits-1:0] model_block(input int f, input int addr);
    logic [block_bits-1:0] blk;
    int y;
    int x0;
    y  = addr / frame_width;
    x0 = addr % frame_width;
    blk = '0;
    for (int i = 0; i < pixels_per_block; i++) begin
      if (inside_tri(f, x0 + i, y)) blk[i*pixel_bits +: pixel_bits] = fill_color;
    end
    return blk;
  endfunction

  task automatic load_triangle(input int f);
    for (int v = 0; v < 3; v++) begin
      tri_v[f][2*v]   = $urandom_range(0, frame_width - 1);
      tri_v[f][2*v+1] = $urandom_range(0, frame_height - 1);
    end
    tri_load <= 1'b1;
    tri_x0   <= coord_bits'(tri_v[f][0]);
    tri_y0   <= coord_bits'(tri_v[f][1]);
    tri_x1   <= coord_bits'(tri_v[f][2]);
    tri_y1   <= coord_bits'(tri_v[f][3]);
    tri_x2   <= coord_bits'(tri_v[f][4]);
    tri_y2   <= coord_bits'(tri_v[f][5]);
  endtask

  // rising edge, drive reset, triangle loads and credit returns
  task automatic drive_inputs();
    if (cyc == 2) sys_rst <= 1'b0;
    // first load pulse stays up until the registers are out of reset
    if (load_req) begin
      load_triangle(load_frame);
      load_req = 1'b0;
    end else if (cyc >= 3) begin
      tri_load <= 1'b0;
    end
    if (cyc >= pause_until) begin
      for (int i = rel_q.size() - 1; i >= 0; i--) begin
        if (rel_q[i] <= cyc) begin
          rel_q.delete(i);
          ready_cnt++;
        end
      end
    end
    if (ready_cnt > 0 && cyc >= pause_until) begin
      credit_return <= 1'b1;
      ready_cnt--;
    end else begin
      credit_return <= 1'b0;
    end
  endtask

  // falling edge, outputs are settled
  task automatic watch_outputs();
    int frame_idx;
    int pause_end;
    if (cyc <= 3 && blk_valid !== 1'b0) begin
      report_problem("blk_valid was high during reset or right after it");
    end else if (blk_valid === 1'b1) begin
      if (outstanding >= init_credits) begin
        report_problem($sformatf("block arrived with %0d blocks already outstanding",
                                 outstanding));
      end
      frame_idx = n_blk / blocks_per_frame;
      check_addr($sformatf("block %0d address", n_blk), exp_addr, blk_addr);
      check_block($sformatf("block %0d data", n_blk),
                  model_block(frame_idx, int'(exp_addr)), blk_data);
      // next triangle goes in while this frame is still being scanned
      if (n_blk % blocks_per_frame == 0) begin
        load_req   = 1'b1;
        load_frame = frame_idx + 1;
      end
      rel_q.push_back(cyc + $urandom_range(0, max_delay));
      if ($urandom_range(0, 31) == 0) begin
        pause_end = cyc + $urandom_range(50, 250);
        if (pause_end > pause_until) pause_until = pause_end;
      end
      outstanding++;
      n_blk++;
      blocks_seen++;
      if (exp_addr == addr_bits'(last_blk_addr)) exp_addr = '0;
      else exp_addr = exp_addr + addr_bits'(pixels_per_block);
    end
    // the DUT samples this return at the next rising edge
    if (credit_return) outstanding--;
  endtask

  initial begin
    int seed_echo;
    seed_echo     = $urandom(32'hb77dc16c);
    sys_rst       = 1'b1;
    tri_load      = 1'b0;
    tri_x0        = '0;
    tri_y0        = '0;
    tri_x1        = '0;
    tri_y1        = '0;
    tri_x2        = '0;
    tri_y2        = '0;
    credit_return = 1'b0;
    load_triangle(0);
    while (n_blk < total_blocks && !timed_out) begin
      @(posedge sys_clk);
      cyc++;
      drive_inputs();
      @(negedge sys_clk);
      watch_outputs();
      if (cyc >= cycle_limit) timed_out = 1'b1;
    end
    if (timed_out) begin
      report_problem($sformatf("timeout after %0d cycles with %0d of %0d blocks received",
                               cyc, n_blk, total_blocks));
    end
    print_counts();
    if (timed_out || value_errs != 0 || other_errs != 0) begin
      $display("** FAIL **");
    end else begin
      $display("** PASS **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: design/block_packer.sv
`default_nettype none

module block_packer
  import raster_pkg::*;
(
  input  wire                    sys_clk,
  input  wire                    sys_rst,
  input  wire                    pix_valid,
  input  wire [coord_bits-1:0]   pix_x,
  input  wire [coord_bits-1:0]   pix_y,
  input  wire                    pix_covered,
  input  wire                    credit_return,
  output logic                   pix_ready,
  output logic                   blk_valid,
  output logic [addr_bits-1:0]   blk_addr,
  output logic [block_bits-1:0]  blk_data
);

  pack_state_t state;

  logic [block_idx_bits-1:0] slot;
  logic [credit_bits-1:0]    credits;
  logic [pixel_bits-1:0]     pix_word;
  logic [addr_bits-1:0]      pix_addr;

  logic accept;
  logic last_accept;
  logic credit_avail;
  logic issue;

  // no pixels taken while a full block waits for a credit
  assign pix_ready = (state == pack_fill);

  assign accept      = pix_valid && pix_ready;
  assign last_accept = accept && (slot == block_idx_bits'(pixels_per_block - 1));

  assign pix_word = pix_covered ? fill_color : '0;
  assign pix_addr = addr_bits'(pix_y) * addr_bits'(frame_width) + addr_bits'(pix_x);

  // a credit coming back this cycle can be spent right away
  assign credit_avail = (credits != '0) || credit_return;
  assign issue = (last_accept || (state == pack_wait_credit)) && credit_avail;

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      state     <= pack_fill;
      slot      <= '0;
      blk_valid <= 1'b0;
    end else begin
      blk_valid <= issue;
      if (accept) begin
        // wraps back to slot zero after the last pixel
        slot <= slot + 1'b1;
      end
      case (state)
        pack_fill: begin
          if (last_accept && !credit_avail) begin
            state <= pack_wait_credit;
          end
        end
        pack_wait_credit: begin
          if (credit_return) begin
            state <= pack_fill;
          end
        end
        default: begin
          state <= pack_fill;
        end
      endcase
    end
  end

  // credit counter, one spent per block and one back per return pulse
  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      credits <= credit_bits'(init_credits);
    end else if (issue && !credit_return) begin
      credits <= credits - 1'b1;
    end else if (credit_return && !issue) begin
      credits <= credits + 1'b1;
    end
  end

  // block payload is written in place
  // slot zero of the next block lands only after blk_valid has been seen
  always_ff @(posedge sys_clk) begin
    if (accept) begin
      blk_data[slot*pixel_bits +: pixel_bits] <= pix_word;
      if (slot == '0) begin
        blk_addr <= pix_addr;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/frame_writer.sv
`default_nettype none

module frame_writer
  import raster_pkg::*;
(
  input  wire                    sys_clk,
  input  wire                    sys_rst,
  input  wire                    tri_load,
  input  wire [coord_bits-1:0]   tri_x0,
  input  wire [coord_bits-1:0]   tri_y0,
  input  wire [coord_bits-1:0]   tri_x1,
  input  wire [coord_bits-1:0]   tri_y1,
  input  wire [coord_bits-1:0]   tri_x2,
  input  wire [coord_bits-1:0]   tri_y2,
  input  wire                    credit_return,
  output logic                   blk_valid,
  output logic [addr_bits-1:0]   blk_addr,
  output logic [block_bits-1:0]  blk_data
);

  // pixel stream between the three stages
  logic [coord_bits-1:0] pix_x;
  logic [coord_bits-1:0] pix_y;
  logic                  pix_valid;
  logic                  pix_ready;
  logic                  pix_covered;

  pixel_scanner i_pixel_scanner (
    .sys_clk   (sys_clk),
    .sys_rst   (sys_rst),
    .pix_ready (pix_ready),
    .pix_x     (pix_x),
    .pix_y     (pix_y),
    .pix_valid (pix_valid)
  );

  triangle_coverage i_triangle_coverage (
    .sys_clk     (sys_clk),
    .sys_rst     (sys_rst),
    .tri_load    (tri_load),
    .tri_x0      (tri_x0),
    .tri_y0      (tri_y0),
    .tri_x1      (tri_x1),
    .tri_y1      (tri_y1),
    .tri_x2      (tri_x2),
    .tri_y2      (tri_y2),
    .pix_x       (pix_x),
    .pix_y       (pix_y),
    .pix_valid   (pix_valid),
    .pix_ready   (pix_ready),
    .pix_covered (pix_covered)
  );

  // packer also owns the write credits and back-pressure
  block_packer i_block_packer (
    .sys_clk       (sys_clk),
    .sys_rst       (sys_rst),
    .pix_valid     (pix_valid),
    .pix_x         (pix_x),
    .pix_y         (pix_y),
    .pix_covered   (pix_covered),
    .credit_return (credit_return),
    .pix_ready     (pix_ready),
    .blk_valid     (blk_valid),
    .blk_addr      (blk_addr),
    .blk_data      (blk_data)
  );

endmodule

`default_nettype wire

// File: design/pixel_scanner.sv
`default_nettype none

module pixel_scanner
  import raster_pkg::*;
(
  input  wire                    sys_clk,
  input  wire                    sys_rst,
  input  wire                    pix_ready,
  output logic [coord_bits-1:0]  pix_x,
  output logic [coord_bits-1:0]  pix_y,
  output logic                   pix_valid
);

  logic advance;
  logic last_col;
  logic last_line;

  // step only when the packer takes the current pixel
  assign advance   = pix_valid && pix_ready;
  assign last_col  = (pix_x == coord_bits'(frame_width - 1));
  assign last_line = (pix_y == coord_bits'(frame_height - 1));

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      pix_valid <= 1'b0;
    end else begin
      // a pixel is always on offer once out of reset
      pix_valid <= 1'b1;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      pix_x <= '0;
      pix_y <= '0;
    end else if (advance) begin
      if (last_col) begin
        pix_x <= '0;
        // end of line, move down or wrap to the top of the frame
        if (last_line) begin
          pix_y <= '0;
        end else begin
          pix_y <= pix_y + 1'b1;
        end
      end else begin
        pix_x <= pix_x + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/raster_pkg.sv
`default_nettype none

package raster_pkg;

  // frame geometry, kept small for short runs
  localparam int frame_width  = 64;
  localparam int frame_height = 48;
  localparam int coord_bits   = 7;

  // one pixel word per screen position
  localparam int pixel_bits = 16;

  // word written for a covered pixel, uncovered pixels are zero
  localparam logic [pixel_bits-1:0] fill_color = 16'h0f0f;

  // block sizing for the memory write port
  localparam int pixels_per_block = 16;
  localparam int block_bits       = 256;
  localparam int block_idx_bits   = 4;

  // pixel address is line * frame_width + column
  localparam int addr_bits = 12;

  // write credits owned by the packer after reset
  localparam int init_credits = 4;
  localparam int credit_bits  = 3;

  // packer FSM
  typedef enum logic {
    pack_fill,
    pack_wait_credit
  } pack_state_t;

endpackage

`default_nettype wire

// File: design/triangle_coverage.sv
`default_nettype none

module triangle_coverage
  import raster_pkg::*;
(
  input  wire                   sys_clk,
  input  wire                   sys_rst,
  input  wire                   tri_load,
  input  wire [coord_bits-1:0]  tri_x0,
  input  wire [coord_bits-1:0]  tri_y0,
  input  wire [coord_bits-1:0]  tri_x1,
  input  wire [coord_bits-1:0]  tri_y1,
  input  wire [coord_bits-1:0]  tri_x2,
  input  wire [coord_bits-1:0]  tri_y2,
  input  wire [coord_bits-1:0]  pix_x,
  input  wire [coord_bits-1:0]  pix_y,
  input  wire                   pix_valid,
  input  wire                   pix_ready,
  output logic                  pix_covered
);

  // vertex order x0 y0 x1 y1 x2 y2
  logic [5:0][coord_bits-1:0] pend_tri;
  logic [5:0][coord_bits-1:0] act_tri;
  logic [5:0][coord_bits-1:0] cur_tri;

  logic first_pix;
  logic signed [2*coord_bits+2:0] e0;
  logic signed [2*coord_bits+2:0] e1;
  logic signed [2*coord_bits+2:0] e2;

  // offset of p from a, crossed with the edge a to b
  function automatic logic signed [2*coord_bits+2:0] edge_fn(
    input logic [coord_bits-1:0] ax,
    input logic [coord_bits-1:0] ay,
    input logic [coord_bits-1:0] bx,
    input logic [coord_bits-1:0] by,
    input logic [coord_bits-1:0] px,
    input logic [coord_bits-1:0] py
  );
    logic signed [coord_bits:0] dx;
    logic signed [coord_bits:0] dy;
    logic signed [coord_bits:0] ex;
    logic signed [coord_bits:0] ey;
    dx = $signed({1'b0, px}) - $signed({1'b0, ax});
    dy = $signed({1'b0, py}) - $signed({1'b0, ay});
    ex = $signed({1'b0, bx}) - $signed({1'b0, ax});
    ey = $signed({1'b0, by}) - $signed({1'b0, ay});
    return dx * ey - dy * ex;
  endfunction

  assign first_pix = pix_valid && (pix_x == '0) && (pix_y == '0);

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      pend_tri <= '0;
      act_tri  <= '0;
    end else begin
      if (tri_load) begin
        pend_tri <= {tri_y2, tri_x2, tri_y1, tri_x1, tri_y0, tri_x0};
      end
      // new frame starts, pending triangle takes over
      if (first_pix && pix_ready) begin
        act_tri <= pend_tri;
      end
    end
  end

  // pixel (0,0) already belongs to the frame of the pending triangle
  assign cur_tri = first_pix ? pend_tri : act_tri;

  assign e0 = edge_fn(cur_tri[0], cur_tri[1], cur_tri[2], cur_tri[3], pix_x, pix_y);
  assign e1 = edge_fn(cur_tri[2], cur_tri[3], cur_tri[4], cur_tri[5], pix_x, pix_y);
  assign e2 = edge_fn(cur_tri[4], cur_tri[5], cur_tri[0], cur_tri[1], pix_x, pix_y);

  // inside for either winding
  assign pix_covered = pix_valid &&
                       (((e0 >= 0) && (e1 >= 0) && (e2 >= 0)) ||
                        ((e0 <= 0) && (e1 <= 0) && (e2 <= 0)));

endmodule

`default_nettype wire

// File: frame_writer.f
+incdir+bench
design/raster_pkg.sv
design/pixel_scanner.sv
design/triangle_coverage.sv
design/block_packer.sv
design/frame_writer.sv
bench/frame_writer_tb.sv
